// ==== dv/dev_tests.txt ====
# kind addr data n lat, all hex. W writes data with byte select n; R reads n words from addr up
# and expects data in each; U expects byte data on the serial line. lat is the least ack latency
R c4000000 00000000 10 2
W c4000000 11223344 f 2
W c4000004 aabbccdd 5 2
W c4000004 55667788 8 2
W c400003c deadbeef 6 2
R c4000000 11223344 1 2
R c4000004 55bb00dd 1 2
R c400003c 00adbe00 1 2
R c4000008 00000000 1 2
W c2000000 ffffffff f 2
R c2000004 00000000 1 2
W 00000010 12345678 f 2
R 00000000 00000000 1 2
R c4000000 11223344 1 2
R c4000004 55bb00dd 1 2
W c0000000 000000a5 1 2
R c0000004 00000001 1 2
U 00000000 000000a5 0 0
R c0000004 00000000 1 2
R c0000000 00000000 1 2
W c0000000 0000003c 1 2
W c0000000 000001c3 1 90
U 00000000 0000003c 0 0
U 00000000 000000c3 0 0
R c0000004 00000000 1 2

// ==== all.f ====
rtl/dev_pkg.sv
rtl/dev_bus_ctrl.sv
rtl/uart_tx_dev.sv
rtl/dsa_buffer_dev.sv
rtl/dev_read_mux.sv
rtl/dev_bus_top.sv
dv/tb_clkgen.sv
dv/dev_bus_properties.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_top -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run.sh: pass"
else
    echo "run.sh: fail"
    exit 1
fi

// ==== dv/tb_top.sv ====
module tb_top;

    localparam int CLKS_PER_BIT = 16;      // Baud divider given to the DUT
    localparam int RST_CYCLES   = 8;       // usr_reset length and stretch length

    logic           clk;
    logic           usr_reset;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    dev_pkg::addr_t wb_adr;
    dev_pkg::be_t   wb_sel;
    dev_pkg::data_t wb_dat_w;              // Host write data
    dev_pkg::data_t wb_dat_r;              // DUT read data
    logic           wb_ack;
    logic           uart_tx;

    // One entry per line of the tests file
    logic [7:0]     t_kind [$];            // W, R or U
    dev_pkg::addr_t t_addr [$];
    dev_pkg::data_t t_data [$];            // Write data or expected value
    logic [31:0]    t_num  [$];            // Byte select for W or word count for R
    logic [31:0]    t_lat  [$];            // Least ack latency in cycles

    logic [7:0]     rx_q [$];              // Bytes decoded from the serial line
    int unsigned    lcg_state = 32'd76964;
    int             errors    = 0;
    int             checks    = 0;
    int             limit     = 0;         // Watchdog length in cycles
    logic           loaded    = 1'b0;      // Reset over and tests read

    tb_clkgen #(.PERIOD(10)) i_clkgen (.clk_o(clk));

    dev_bus_top #(
        .RST_CYCLES   (RST_CYCLES),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_dut (
        .clk       (clk),
        .usr_reset (usr_reset),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_we_i   (wb_we),
        .wb_adr_i  (wb_adr),
        .wb_sel_i  (wb_sel),
        .wb_dat_i  (wb_dat_w),
        .wb_dat_o  (wb_dat_r),
        .wb_ack_o  (wb_ack),
        .uart_tx_o (uart_tx)
    );

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic finish_run(input logic timed_out);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (!timed_out && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic load_tests();
        int          fd;
        int          got;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] n;
        logic [31:0] l;
        fd = $fopen("dv/dev_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/dev_tests.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            got = $sscanf(line, "%c %h %h %h %h", kind, a, d, n, l);
            if (got == 5 && kind != "#") begin   // Skip comments and blank lines
                t_kind.push_back(kind);
                t_addr.push_back(a);
                t_data.push_back(d);
                t_num.push_back(n);
                t_lat.push_back(l);
            end
        end
        $fclose(fd);
    endtask

    // ----------------------------------------
    // Bus driver
    // ----------------------------------------
    task automatic bus_access(input logic we, input dev_pkg::addr_t addr,
                              input dev_pkg::data_t data, input dev_pkg::be_t sel,
                              output dev_pkg::data_t rdata, output int cycles);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= addr;
        wb_sel   <= sel;
        wb_dat_w <= data;
        cycles = 0;
        do begin
            @(negedge clk);                // Ack and data settled here
            cycles++;
        end while (!wb_ack);
        rdata = wb_dat_r;
        @(posedge clk);                    // Ack seen so drop the strobe
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    // Plain accesses take 2 cycles and a stalled UART write at least lat
    task automatic check_latency(input dev_pkg::addr_t addr, input int cycles,
                                 input logic [31:0] lat);
        checks++;
        if (cycles < int'(lat) || (lat == 32'd2 && cycles != 2)) begin
            errors++;
            $display("Ack for address %h came after %0d cycles, expected %0d",
                     addr, cycles, lat);
        end
    endtask

    task automatic run_line(input int i);
        dev_pkg::data_t rdata;
        dev_pkg::addr_t addr;
        int             cycles;
        logic [7:0]     rx_byte;
        case (t_kind[i])
            "W": begin
                bus_access(1'b1, t_addr[i], t_data[i], dev_pkg::be_t'(t_num[i]),
                           rdata, cycles);
                check_latency(t_addr[i], cycles, t_lat[i]);
            end
            "R": begin
                for (int k = 0; k < int'(t_num[i]); k++) begin
                    addr = t_addr[i] + dev_pkg::addr_t'(4 * k);  // Next word up
                    bus_access(1'b0, addr, '0, 4'hf, rdata, cycles);
                    check_latency(addr, cycles, t_lat[i]);
                    checks++;
                    if (rdata !== t_data[i]) begin
                        errors++;
                        $display("ERR wb_dat_o at %h: expected %h got %h",
                                 addr, t_data[i], rdata);
                    end
                end
            end
            "U": begin
                while (rx_q.size() == 0) @(negedge clk);  // Wait for the decoder
                rx_byte = rx_q.pop_front();
                checks++;
                if (rx_byte !== t_data[i][7:0]) begin
                    errors++;
                    $display("ERR uart_tx_o byte: expected %h got %h",
                             t_data[i][7:0], rx_byte);
                end
            end
            default: begin
                errors++;
                $display("Test entry %0d has an unknown kind", i);
            end
        endcase
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int unsigned gap;
        usr_reset = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_sel    = '0;
        wb_dat_w  = '0;
        repeat (RST_CYCLES) @(posedge clk);
        usr_reset <= 1'b0;
        do @(negedge clk); while (i_dut.rst);    // Stretched reset over
        checks++;
        if (uart_tx !== 1'b1) begin
            errors++;
            $display("ERR uart_tx_o after reset: expected 1 got %h", uart_tx);
        end
        load_tests();
        if (t_kind.size() == 0) begin
            errors++;
            $display("No test lines were read");
        end
        limit  = t_kind.size() * (12 * CLKS_PER_BIT + 20);
        loaded = 1'b1;
        foreach (t_kind[i]) begin
            gap = (lcg_next() >> 16) % 4;  // Idle gap of 0 to 3 cycles
            repeat (gap) @(posedge clk);
            run_line(i);
        end
        // Room for one more frame to reach the decoder
        repeat (12 * CLKS_PER_BIT) @(posedge clk);
        checks++;
        if (rx_q.size() != 0) begin
            errors++;
            $display("%0d bytes on the serial line were not expected", rx_q.size());
        end
        finish_run(1'b0);
    end

    // Serial decoder sampling each bit in its middle
    initial begin
        logic [7:0] rx_byte;
        do @(negedge clk); while (!loaded);
        forever begin
            do @(negedge clk); while (uart_tx !== 1'b0);  // Falling start edge
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            if (uart_tx !== 1'b0) begin
                errors++;
                $display("Start bit on uart_tx_o did not hold low");
            end
            for (int b = 0; b < 8; b++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                rx_byte[b] = uart_tx;      // LSB first
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            checks++;
            if (uart_tx !== 1'b1) begin
                errors++;
                $display("Stop bit on uart_tx_o was not high");
            end
            repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Let the frame finish
            rx_q.push_back(rx_byte);
        end
    end

    // Watchdog sized from the number of test lines
    initial begin
        repeat (4 * RST_CYCLES) @(posedge clk);
        if (loaded) begin
            repeat (limit) @(posedge clk);
        end
        $display("Timeout, the tests did not finish in time");
        finish_run(1'b1);
    end

endmodule

// ==== dv/dev_bus_properties.sv ====
module dev_bus_properties (
    input logic clk,
    input logic rst_i,                     // Stretched reset
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,                     // Combined bus ack
    input logic tx_i                       // Serial line
);

    // ----------------------------------------
    // Wishbone handshake
    // ----------------------------------------
    ack_with_request: assert property (@(posedge clk) disable iff (rst_i)
        ack_i |-> (cyc_i && stb_i))
        else $error("Bus ack without cyc and stb");

    single_cycle_ack: assert property (@(posedge clk) disable iff (rst_i)
        ack_i |=> !ack_i)
        else $error("Bus ack high in two cycles in a row");

    // Quiet bus and idle line once reset has been seen for a full cycle
    quiet_reset: assert property (@(posedge clk)
        (rst_i && $past(rst_i)) |-> (!ack_i && tx_i))
        else $error("Ack or serial activity during reset");

endmodule

bind dev_bus_top dev_bus_properties i_props (
    .clk   (clk),
    .rst_i (rst),
    .cyc_i (wb_cyc_i),
    .stb_i (wb_stb_i),
    .ack_i (wb_ack_o),
    .tx_i  (uart_tx_o)
);

// ==== dv/tb_clkgen.sv ====
module tb_clkgen #(
    parameter int PERIOD = 10              // Clock period in time units
) (
    output logic clk_o
);

    // Free running, starts low
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

// ==== rtl/dev_bus_top.sv ====
module dev_bus_top #(
    parameter int RST_CYCLES   = 8,        // Stretched reset length
    parameter int CLKS_PER_BIT = 16        // UART baud divider
) (
    input  logic           clk,
    input  logic           usr_reset,
    input  logic           wb_cyc_i,
    input  logic           wb_stb_i,
    input  logic           wb_we_i,
    input  dev_pkg::addr_t wb_adr_i,
    input  dev_pkg::be_t   wb_sel_i,
    input  dev_pkg::data_t wb_dat_i,
    output dev_pkg::data_t wb_dat_o,
    output logic           wb_ack_o,
    output logic           uart_tx_o
);

    logic           rst;                   // Stretched reset for all blocks
    logic           uart_sel;
    logic           dsa_sel;
    logic           unmapped_ack;
    logic           uart_ack;
    logic           dsa_ack;
    dev_pkg::data_t uart_rdata;
    dev_pkg::data_t dsa_rdata;

    // Reset stretcher and address decoder
    dev_bus_ctrl #(
        .RST_CYCLES(RST_CYCLES)
    ) i_ctrl (
        .clk            (clk),
        .usr_reset      (usr_reset),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_adr_i       (wb_adr_i),
        .wb_ack_i       (wb_ack_o),        // Combined ack fed back
        .rst_o          (rst),
        .uart_sel_o     (uart_sel),
        .dsa_sel_o      (dsa_sel),
        .unmapped_ack_o (unmapped_ack)
    );

    uart_tx_dev #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_uart (
        .clk       (clk),
        .rst_i     (rst),
        .sel_i     (uart_sel),
        .we_i      (wb_we_i),
        .reg_i     (wb_adr_i[3:2]),        // Register word offset
        .wdata_i   (wb_dat_i),
        .ack_o     (uart_ack),
        .rd_data_o (uart_rdata),
        .tx_o      (uart_tx_o)
    );

    dsa_buffer_dev i_dsa (
        .clk       (clk),
        .rst_i     (rst),
        .sel_i     (dsa_sel),
        .we_i      (wb_we_i),
        .index_i   (wb_adr_i[5:2]),        // Buffer word index
        .be_i      (wb_sel_i),
        .wdata_i   (wb_dat_i),
        .ack_o     (dsa_ack),
        .rd_data_o (dsa_rdata)
    );

    // Bus response
    dev_read_mux i_mux (
        .uart_ack_i     (uart_ack),
        .dsa_ack_i      (dsa_ack),
        .unmapped_ack_i (unmapped_ack),
        .uart_data_i    (uart_rdata),
        .dsa_data_i     (dsa_rdata),
        .ack_o          (wb_ack_o),
        .rd_data_o      (wb_dat_o)
    );

endmodule

// ==== rtl/dev_read_mux.sv ====
module dev_read_mux (
    input  logic           uart_ack_i,
    input  logic           dsa_ack_i,
    input  logic           unmapped_ack_i,  // Carries no data
    input  dev_pkg::data_t uart_data_i,
    input  dev_pkg::data_t dsa_data_i,
    output logic           ack_o,
    output dev_pkg::data_t rd_data_o
);

    // At most one responder is active in a cycle
    assign ack_o = uart_ack_i | dsa_ack_i | unmapped_ack_i;

    // ----------------------------------------
    // Data select
    // ----------------------------------------
    always_comb begin
        if (uart_ack_i) begin
            rd_data_o = uart_data_i;
        end else if (dsa_ack_i) begin
            rd_data_o = dsa_data_i;
        end else begin
            rd_data_o = '0;                // Unmapped or idle bus
        end
    end

endmodule

// ==== rtl/dsa_buffer_dev.sv ====
module dsa_buffer_dev (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           sel_i,
    input  logic           we_i,
    input  logic [3:0]     index_i,        // Word index
    input  dev_pkg::be_t   be_i,
    input  dev_pkg::data_t wdata_i,
    output logic           ack_o,
    output dev_pkg::data_t rd_data_o
);

    dev_pkg::data_t mem [dev_pkg::DSA_WORDS];  // Accelerator operand buffer

    // ----------------------------------------
    // Storage and ack
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_o <= 1'b0;
            for (int i = 0; i < dev_pkg::DSA_WORDS; i++) begin
                mem[i] <= '0;              // Buffer starts empty
            end
        end else begin
            ack_o <= sel_i;                // One cycle after the select
            if (sel_i && we_i) begin
                for (int b = 0; b < 4; b++) begin
                    // Only lanes with their select bit set
                    if (be_i[b]) begin
                        mem[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

    // Read data comes out together with the ack
    always_ff @(posedge clk) begin
        if (sel_i) begin
            rd_data_o <= we_i ? '0 : mem[index_i];  // Writes answer zero
        end
    end

endmodule

// ==== rtl/uart_tx_dev.sv ====
module uart_tx_dev #(
    parameter int CLKS_PER_BIT = 16        // Clock cycles per serial bit
) (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           sel_i,
    input  logic           we_i,
    input  logic [1:0]     reg_i,          // Register word offset
    input  dev_pkg::data_t wdata_i,
    output logic           ack_o,
    output dev_pkg::data_t rd_data_o,
    output logic           tx_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    dev_pkg::uart_state_t state;
    logic [CNT_W-1:0]     baud_cnt;        // Cycle within the current bit
    logic [2:0]           bit_idx;         // Data bit being sent
    logic [7:0]           shift_q;         // Outgoing byte, LSB first
    logic                 busy;
    logic                 bit_end;         // Last cycle of a bit
    logic                 tx_req;          // Write to the TX register
    logic                 tx_wr;           // TX write accepted

    assign busy    = (state != dev_pkg::IDLE);
    assign bit_end = busy && (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign tx_req  = sel_i && we_i && (reg_i == dev_pkg::UART_REG_TX);
    assign tx_wr   = tx_req && !busy;

    // ----------------------------------------
    // Register interface
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= sel_i && (!tx_req || !busy);  // TX write stalls while busy
        end
    end

    // Status returns busy in bit 0, every other read is zero
    always_ff @(posedge clk) begin
        if (sel_i && !we_i && (reg_i == dev_pkg::UART_REG_STATUS)) begin
            rd_data_o <= dev_pkg::data_t'(busy);
        end else begin
            rd_data_o <= '0;
        end
    end

    // ----------------------------------------
    // Frame sequencer
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state    <= dev_pkg::IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx_o     <= 1'b1;              // Line idles high
        end else begin
            baud_cnt <= (!busy || bit_end) ? '0 : baud_cnt + 1'b1;
            case (state)
                dev_pkg::IDLE:  if (tx_wr) state <= dev_pkg::START;
                dev_pkg::START: begin
                    if (bit_end) begin
                        state   <= dev_pkg::DATA;
                        bit_idx <= '0;
                    end
                end
                dev_pkg::DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= dev_pkg::STOP;
                    end
                end
                default:        if (bit_end) state <= dev_pkg::IDLE;
            endcase
            // Line follows the state one cycle later
            tx_o <= (state == dev_pkg::START) ? 1'b0 :
                    (state == dev_pkg::DATA)  ? shift_q[0] : 1'b1;
        end
    end

    // Byte shifter
    always_ff @(posedge clk) begin
        if (tx_wr) begin
            shift_q <= wdata_i[7:0];       // Low byte only
        end else if ((state == dev_pkg::DATA) && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

// ==== rtl/dev_bus_ctrl.sv ====
module dev_bus_ctrl #(
    parameter int RST_CYCLES = 8           // Cycles of reset after usr_reset falls
) (
    input  logic           clk,
    input  logic           usr_reset,
    input  logic           wb_cyc_i,
    input  logic           wb_stb_i,
    input  dev_pkg::addr_t wb_adr_i,
    input  logic           wb_ack_i,       // Ack of the current request
    output logic           rst_o,
    output logic           uart_sel_o,
    output logic           dsa_sel_o,
    output logic           unmapped_ack_o
);

    logic [RST_CYCLES-1:0] rst_sr;         // Reset stretch shift register
    dev_pkg::page_t        page;
    logic                  req;            // New request waiting for a device
    logic                  hit_uart;
    logic                  hit_dsa;

    // ----------------------------------------
    // Reset stretcher
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (usr_reset) begin
            rst_sr <= '1;                  // Refill while held
        end else begin
            rst_sr <= {rst_sr[RST_CYCLES-2:0], 1'b0};
        end
    end

    // High during usr_reset and until the last one shifts out
    assign rst_o = usr_reset | rst_sr[RST_CYCLES-1];

    // ----------------------------------------
    // Address decoder
    // ----------------------------------------
    assign page     = wb_adr_i[31:24];
    assign hit_uart = (page == dev_pkg::UART_PAGE);
    assign hit_dsa  = (page == dev_pkg::DSA_PAGE);

    // The ack cycle of a request must not select it again
    assign req = wb_cyc_i & wb_stb_i & ~wb_ack_i & ~rst_o;

    assign uart_sel_o = req & hit_uart;
    assign dsa_sel_o  = req & hit_dsa;

    // Unmapped pages answer zero data one cycle later
    always_ff @(posedge clk) begin
        if (rst_o) begin
            unmapped_ack_o <= 1'b0;
        end else begin
            unmapped_ack_o <= req & ~hit_uart & ~hit_dsa;
        end
    end

endmodule

// ==== rtl/dev_pkg.sv ====
package dev_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    typedef logic [31:0] addr_t;           // Wishbone byte address
    typedef logic [31:0] data_t;           // Wishbone data word
    typedef logic [3:0]  be_t;             // One select bit per byte lane
    typedef logic [7:0]  page_t;           // Top address byte, picks the device

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    localparam page_t UART_PAGE = 8'hC0;   // 0xC000_0000 - 0xC0FF_FFFF
    localparam page_t DSA_PAGE  = 8'hC4;   // 0xC400_0000 - 0xC4FF_FFFF

    // UART register word offsets, from address bits 3:2
    localparam logic [1:0] UART_REG_TX     = 2'd0;
    localparam logic [1:0] UART_REG_STATUS = 2'd1;

    // Accelerator data buffer depth, indexed by address bits 5:2
    localparam int DSA_WORDS = 16;

    // UART frame sequencer
    typedef enum logic [1:0] {
        IDLE,                              // Line high, ready for a byte
        START,                             // Low start bit
        DATA,                              // Eight data bits, LSB first
        STOP                               // High stop bit
    } uart_state_t;

endpackage
